// File: hw/tpu_isa_pkg.sv
`default_nettype none

package tpu_isa_pkg;

    // ============================================================
    // Basic widths
    // ============================================================

    typedef logic [31:0] instr_t;   // Raw instruction word
    typedef logic [7:0]  pc_t;      // Instruction memory address
    typedef logic [7:0]  arg_t;     // One argument byte
    typedef logic [1:0]  flags_t;   // Low flag bits of the word

    // ============================================================
    // Opcodes
    // ============================================================

    // Kept subset only, any other code runs as NOP
    typedef enum logic [5:0] {
        NOP         = 6'h00,
        RD_HOST_MEM = 6'h01,    // Host to UB
        WR_HOST_MEM = 6'h02,    // UB to host
        MATMUL      = 6'h10,    // Clears accumulator first
        MATMUL_ACC  = 6'h12,    // Adds onto accumulator
        RELU        = 6'h18,
        RELU6       = 6'h19,
        SYNC        = 6'h30,    // Bank swap plus wait
        CFG_REG     = 6'h31,
        HALT        = 6'h3F
    } opcode_e;

    // ============================================================
    // Instruction layout
    // ============================================================

    // Field order matches bits 31 down to 0
    typedef struct packed {
        opcode_e opcode;    // [31:26]
        arg_t    arg1;      // [25:18]
        arg_t    arg2;      // [17:10]
        arg_t    arg3;      // [9:2]
        flags_t  flags;     // [1:0]
    } instr_fields_t;

    // arg1 is usually a source address,
    // arg2 a destination or accumulator address,
    // arg3 a row count or element count.
    // For DMA, SYNC and CFG_REG the pair arg2:arg3 forms
    // one 16 bit value, arg2 being the upper byte.

endpackage

`default_nettype wire

// File: hw/tpu_ctrl_pkg.sv
`default_nettype none

package tpu_ctrl_pkg;

    import tpu_isa_pkg::*;

    // ============================================================
    // Widths
    // ============================================================

    typedef logic [8:0]  ub_addr_t;     // Bank bit on top of 8 bit address
    typedef logic [15:0] len_t;         // Lengths, timeouts, params
    typedef logic [2:0]  unit_mask_t;   // [0] systolic [1] vector [2] DMA

    // ============================================================
    // Modes and states
    // ============================================================

    typedef enum logic [1:0] {
        SYS_MATMUL = 2'd0,
        SYS_ACCUM  = 2'd2
    } sys_mode_e;

    typedef enum logic [3:0] {
        VPU_RELU  = 4'd1,
        VPU_RELU6 = 4'd2
    } vpu_mode_e;

    typedef enum logic {
        SYNC_IDLE,
        SYNC_WAIT
    } sync_state_e;

    // ============================================================
    // Datapath command bundles
    // ============================================================

    typedef struct packed {
        logic      start;       // One cycle pulse
        sys_mode_e mode;
        arg_t      rows;
        logic      is_signed;
        logic      transpose;
        arg_t      acc_addr;
        logic      acc_clear;
    } sys_cmd_t;

    typedef struct packed {
        logic     rd_en;
        logic     wr_en;
        ub_addr_t rd_addr;
        ub_addr_t wr_addr;
        ub_addr_t rd_count;     // Burst length in words
        ub_addr_t wr_count;
    } ub_cmd_t;

    typedef struct packed {
        logic wr_en;
        logic rd_en;
        arg_t addr;
    } acc_cmd_t;

    typedef struct packed {
        logic      start;
        vpu_mode_e mode;
        arg_t      in_addr;
        arg_t      out_addr;
        arg_t      length;
        len_t      param;       // From config file, or zero
    } vpu_cmd_t;

    typedef struct packed {
        logic   start;
        logic   dir;            // 0 host to UB, 1 UB to host
        arg_t   ub_addr;
        len_t   length;
        flags_t elem_sz;        // 0 8b, 1 16b, 2 32b
    } dma_cmd_t;

    // Exec to sync unit
    typedef struct packed {
        logic       wait_en;
        unit_mask_t mask;
        len_t       timeout;
    } sync_req_t;

    // Exec to config registers
    typedef struct packed {
        logic wr_en;
        arg_t addr;
        len_t data;
    } cfg_wr_t;

endpackage

`default_nettype wire

// File: hw/tpu_fetch.sv
`timescale 1ns/1ns
`default_nettype none

module tpu_fetch import tpu_isa_pkg::*; (
    input  wire           clk,
    input  wire           rst_n,
    input  instr_t        instr_data,   // Combinational memory return
    input  wire           stall,        // Any unit busy or sync wait
    input  wire           halted,       // From exec stage latch
    output pc_t           instr_addr,
    output logic          fetch_valid,
    output instr_fields_t fetch_instr
);

    // ============================================================
    // Program counter and valid
    // ============================================================

    pc_t    pc;
    instr_t ir;
    logic   advance;

    assign advance = !stall && !halted; // Frozen on either

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc          <= '0;
            fetch_valid <= 1'b0;
        end else if (advance) begin
            pc          <= pc + pc_t'(1);
            fetch_valid <= 1'b1;        // First load makes IR meaningful
        end
    end

    // ============================================================
    // Instruction register
    // ============================================================

    // Qualified by fetch_valid downstream
    always_ff @(posedge clk) begin
        if (advance) begin
            ir <= instr_data;
        end
    end

    assign instr_addr  = pc;
    assign fetch_instr = instr_fields_t'(ir);   // Split into fields

    // Address must not move once a stall is seen
    a_pc_hold_on_stall: assert property (
        @(posedge clk) disable iff (!rst_n)
        stall |=> $stable(instr_addr)
    ) else $error("instr_addr moved under stall");

endmodule

`default_nettype wire

// File: hw/tpu_sync_unit.sv
`timescale 1ns/1ns
`default_nettype none

module tpu_sync_unit import tpu_ctrl_pkg::*; (
    input  wire       clk,
    input  wire       rst_n,
    input  sync_req_t sync_req,     // One cycle request from exec
    input  wire       sys_busy,
    input  wire       vpu_busy,
    input  wire       dma_busy,
    output logic      sync_active
);

    sync_state_e state;
    unit_mask_t  mask_q;        // Units being waited on
    len_t        timeout_q;
    len_t        count;         // Cycles spent in SYNC_WAIT
    unit_mask_t  busy_vec;
    logic        units_idle;
    logic        timed_out;

    assign busy_vec   = {dma_busy, vpu_busy, sys_busy};
    assign units_idle = (busy_vec & mask_q) == '0;
    assign timed_out  = count >= timeout_q;

    // ============================================================
    // Wait FSM
    // ============================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= SYNC_IDLE;
            mask_q    <= '0;
            timeout_q <= '0;
            count     <= '0;
        end else begin
            case (state)
                SYNC_IDLE: begin
                    if (sync_req.wait_en) begin
                        state     <= SYNC_WAIT;
                        mask_q    <= sync_req.mask;
                        timeout_q <= sync_req.timeout;
                        count     <= '0;
                    end
                end
                SYNC_WAIT: begin
                    if (units_idle || timed_out) begin
                        state <= SYNC_IDLE;     // Release the pipeline
                    end else begin
                        count <= count + len_t'(1);
                    end
                end
                default: state <= SYNC_IDLE;
            endcase
        end
    end

    assign sync_active = (state == SYNC_WAIT);

    // Counter bounded by the value captured at request time
    a_count_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == SYNC_WAIT) |-> (count <= timeout_q)
    ) else $error("sync counter passed timeout");

endmodule

`default_nettype wire

// File: hw/tpu_cfg_regs.sv
`timescale 1ns/1ns
`default_nettype none

module tpu_cfg_regs import tpu_ctrl_pkg::*; #(
    parameter int CFG_DEPTH = 16
) (
    input  wire                         clk,
    input  wire                         rst_n,
    input  cfg_wr_t                     cfg_wr,
    input  wire [$clog2(CFG_DEPTH)-1:0] cfg_rd_idx,
    output len_t                        cfg_rd_data
);

    localparam int IDX_W = $clog2(CFG_DEPTH);

    len_t regs [CFG_DEPTH];
    logic wr_hit;

    assign wr_hit = cfg_wr.wr_en && (cfg_wr.addr < CFG_DEPTH);   // Drop out of range

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < CFG_DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_hit) begin
            regs[cfg_wr.addr[IDX_W-1:0]] <= cfg_wr.data;
        end
    end

    assign cfg_rd_data = regs[cfg_rd_idx];  // Same cycle read

    // Program writing a register that does not exist
    a_cfg_addr_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        cfg_wr.wr_en |-> (cfg_wr.addr < CFG_DEPTH)
    ) else $error("CFG_REG write to address %0d ignored", cfg_wr.addr);

endmodule

`default_nettype wire

// File: hw/tpu_exec_stage.sv
`timescale 1ns/1ns
`default_nettype none

module tpu_exec_stage import tpu_isa_pkg::*, tpu_ctrl_pkg::*; #(
    parameter int CFG_DEPTH = 16
) (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          fetch_valid,
    input  instr_fields_t                fetch_instr,
    input  wire                          stall,
    input  len_t                         cfg_rd_data,
    output logic                         halted,
    output sys_cmd_t                     sys_cmd,
    output ub_cmd_t                      ub_cmd,
    output acc_cmd_t                     acc_cmd,
    output vpu_cmd_t                     vpu_cmd,
    output dma_cmd_t                     dma_cmd,
    output sync_req_t                    sync_req,
    output cfg_wr_t                      cfg_wr,
    output logic [$clog2(CFG_DEPTH)-1:0] cfg_rd_idx,
    output logic                         ub_buf_sel,
    output logic                         acc_buf_sel,
    output logic                         halt_req,
    output logic                         interrupt_en
);

    localparam int IDX_W = $clog2(CFG_DEPTH);

    // ============================================================
    // Execute register and state
    // ============================================================

    logic          ex_valid;
    instr_fields_t ex_instr;
    logic          take;        // Fetch reg moves into exec
    logic          issue;       // Commands go out this cycle

    assign take  = fetch_valid && !stall;   // Else bubble
    assign issue = ex_valid && !halted;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid    <= 1'b0;
            ub_buf_sel  <= 1'b0;
            acc_buf_sel <= 1'b0;
            halted      <= 1'b0;
        end else begin
            ex_valid <= take;
            if (issue && ex_instr.opcode == SYNC) begin
                ub_buf_sel  <= ~ub_buf_sel;     // Swap ping-pong banks
                acc_buf_sel <= ~acc_buf_sel;
            end
            if (issue && ex_instr.opcode == HALT) begin
                halted <= 1'b1;                 // Sticky until reset
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            ex_instr <= fetch_instr;
        end
    end

    assign halt_req     = halted;
    assign interrupt_en = halted;
    assign cfg_rd_idx   = IDX_W'(ex_instr.flags);  // Param register index

    // ============================================================
    // Command generation
    // ============================================================

    always_comb begin
        sys_cmd  = '0;
        ub_cmd   = '0;
        acc_cmd  = '0;
        vpu_cmd  = '0;
        dma_cmd  = '0;
        sync_req = '0;
        cfg_wr   = '0;
        if (issue) begin
            case (ex_instr.opcode)
                RD_HOST_MEM, WR_HOST_MEM: begin
                    dma_cmd.start   = 1'b1;
                    dma_cmd.dir     = (ex_instr.opcode == WR_HOST_MEM);
                    dma_cmd.ub_addr = ex_instr.arg1;
                    dma_cmd.length  = {ex_instr.arg2, ex_instr.arg3};
                    dma_cmd.elem_sz = ex_instr.flags;
                end
                MATMUL, MATMUL_ACC: begin
                    sys_cmd.start     = 1'b1;
                    sys_cmd.mode      = (ex_instr.opcode == MATMUL_ACC) ? SYS_ACCUM
                                                                        : SYS_MATMUL;
                    sys_cmd.rows      = ex_instr.arg3;
                    sys_cmd.is_signed = ex_instr.flags[1];
                    sys_cmd.transpose = ex_instr.flags[0];
                    sys_cmd.acc_addr  = ex_instr.arg2;
                    sys_cmd.acc_clear = (ex_instr.opcode == MATMUL);
                    // Operands from the active UB bank
                    ub_cmd.rd_en      = 1'b1;
                    ub_cmd.rd_addr    = {ub_buf_sel, ex_instr.arg1};
                    ub_cmd.rd_count   = ub_addr_t'(1);
                    acc_cmd.wr_en     = 1'b1;
                    acc_cmd.addr      = ex_instr.arg2;
                end
                RELU, RELU6: begin
                    vpu_cmd.start    = 1'b1;
                    vpu_cmd.mode     = (ex_instr.opcode == RELU6) ? VPU_RELU6 : VPU_RELU;
                    vpu_cmd.in_addr  = ex_instr.arg1;
                    vpu_cmd.out_addr = ex_instr.arg2;
                    vpu_cmd.length   = ex_instr.arg3;
                    vpu_cmd.param    = ex_instr.flags[0] ? cfg_rd_data : '0;
                    acc_cmd.rd_en    = 1'b1;
                    acc_cmd.addr     = ex_instr.arg1;
                    // Results land in the inactive UB bank
                    ub_cmd.wr_en     = 1'b1;
                    ub_cmd.wr_addr   = {~ub_buf_sel, ex_instr.arg2};
                    ub_cmd.wr_count  = ub_addr_t'(1);
                end
                SYNC: begin
                    sync_req.wait_en = 1'b1;
                    sync_req.mask    = ex_instr.arg1[2:0];
                    sync_req.timeout = {ex_instr.arg2, ex_instr.arg3};
                end
                CFG_REG: begin
                    cfg_wr.wr_en = 1'b1;
                    cfg_wr.addr  = ex_instr.arg1;
                    cfg_wr.data  = {ex_instr.arg2, ex_instr.arg3};
                end
                default: ;  // NOP, HALT and retired opcodes
            endcase
        end
    end

    // Only one compute or transfer unit launched per cycle
    a_single_start: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0({sys_cmd.start, vpu_cmd.start, dma_cmd.start})
    ) else $error("more than one unit started");

endmodule

`default_nettype wire

// File: hw/tpu_controller.sv
`timescale 1ns/1ns
`default_nettype none

module tpu_controller import tpu_isa_pkg::*, tpu_ctrl_pkg::*; #(
    parameter int CFG_DEPTH = 16
) (
    input  wire      clk,
    input  wire      rst_n,
    output pc_t      instr_addr,
    input  instr_t   instr_data,
    input  wire      sys_busy,
    input  wire      vpu_busy,
    input  wire      dma_busy,
    output sys_cmd_t sys_cmd,
    output ub_cmd_t  ub_cmd,
    output acc_cmd_t acc_cmd,
    output vpu_cmd_t vpu_cmd,
    output dma_cmd_t dma_cmd,
    output logic     ub_buf_sel,
    output logic     acc_buf_sel,
    output logic     halt_req,
    output logic     interrupt_en,
    output logic     pipeline_stall
);

    localparam int IDX_W = $clog2(CFG_DEPTH);

    logic             fetch_valid;
    instr_fields_t    fetch_instr;
    logic             halted;
    logic             sync_active;
    sync_req_t        sync_req;
    cfg_wr_t          cfg_wr;
    logic [IDX_W-1:0] cfg_rd_idx;
    len_t             cfg_rd_data;

    // Busy units and the sync wait freeze both stages
    assign pipeline_stall = sys_busy | vpu_busy | dma_busy | sync_active;

    // ============================================================
    // Stages
    // ============================================================

    tpu_fetch u_fetch (
        .clk(clk), .rst_n(rst_n),
        .instr_data(instr_data), .stall(pipeline_stall), .halted(halted),
        .instr_addr(instr_addr), .fetch_valid(fetch_valid), .fetch_instr(fetch_instr)
    );

    tpu_exec_stage #(.CFG_DEPTH(CFG_DEPTH)) u_exec (
        .clk(clk), .rst_n(rst_n),
        .fetch_valid(fetch_valid), .fetch_instr(fetch_instr),
        .stall(pipeline_stall), .cfg_rd_data(cfg_rd_data), .halted(halted),
        .sys_cmd(sys_cmd), .ub_cmd(ub_cmd), .acc_cmd(acc_cmd),
        .vpu_cmd(vpu_cmd), .dma_cmd(dma_cmd),
        .sync_req(sync_req), .cfg_wr(cfg_wr), .cfg_rd_idx(cfg_rd_idx),
        .ub_buf_sel(ub_buf_sel), .acc_buf_sel(acc_buf_sel),
        .halt_req(halt_req), .interrupt_en(interrupt_en)
    );

    // ============================================================
    // Support blocks
    // ============================================================

    tpu_sync_unit u_sync (
        .clk(clk), .rst_n(rst_n), .sync_req(sync_req),
        .sys_busy(sys_busy), .vpu_busy(vpu_busy), .dma_busy(dma_busy),
        .sync_active(sync_active)
    );

    tpu_cfg_regs #(.CFG_DEPTH(CFG_DEPTH)) u_cfg (
        .clk(clk), .rst_n(rst_n), .cfg_wr(cfg_wr),
        .cfg_rd_idx(cfg_rd_idx), .cfg_rd_data(cfg_rd_data)
    );

endmodule

`default_nettype wire

// File: tests/tb_tpu_controller.sv
`timescale 1ns/1ns
`default_nettype none

module tb_tpu_controller import tpu_isa_pkg::*, tpu_ctrl_pkg::*; ();

    // One record per pulse-producing instruction
    typedef struct packed {
        sys_cmd_t sys;
        ub_cmd_t  ub;
        acc_cmd_t acc;
        vpu_cmd_t vpu;
        dma_cmd_t dma;
    } cmd_set_t;

    typedef struct packed {
        logic [2:0] units;      // Same bit order as unit_mask_t
        logic [7:0] len;
    } busy_win_t;

    logic      clk = 1'b0;
    logic      rst_n = 1'b0;
    logic      sys_busy = 1'b0;
    logic      vpu_busy = 1'b0;
    logic      dma_busy = 1'b0;
    pc_t       instr_addr;
    instr_t    instr_data;
    sys_cmd_t  sys_cmd;
    ub_cmd_t   ub_cmd;
    acc_cmd_t  acc_cmd;
    vpu_cmd_t  vpu_cmd;
    dma_cmd_t  dma_cmd;
    logic      ub_buf_sel;
    logic      acc_buf_sel;
    logic      halt_req;
    logic      interrupt_en;
    logic      pipeline_stall;

    instr_t    prog [256];          // Instruction memory image
    cmd_set_t  exp_q [$];           // Expected commands in program order
    busy_win_t win_q [$];           // Busy window per SYNC
    cmd_set_t  exp_head = '0;
    logic      exp_avail = 1'b0;
    cmd_set_t  seen;
    logic      any_pulse;
    logic      busy_any;
    logic      quiet_stall;         // Stall held by sync wait alone
    len_t      cfg_model [16];
    logic      bank_model = 1'b0;
    int        n_instr = 0;
    int        busy_budget = 0;     // Worst case busy cycles
    int        cycle_limit = 0;
    int        cycle_count = 0;
    int        seed = 32'h9cc8_a343;
    int        sys_left = 0;
    int        vpu_left = 0;
    int        dma_left = 0;
    logic      bank_seen = 1'b0;
    busy_win_t win;

    always #10 clk = ~clk;

    assign instr_data  = prog[instr_addr];  // Combinational memory
    assign seen        = {sys_cmd, ub_cmd, acc_cmd, vpu_cmd, dma_cmd};
    assign any_pulse   = sys_cmd.start | vpu_cmd.start | dma_cmd.start | ub_cmd.rd_en
                       | ub_cmd.wr_en | acc_cmd.wr_en | acc_cmd.rd_en;
    assign busy_any    = sys_busy | vpu_busy | dma_busy;
    assign quiet_stall = pipeline_stall & ~busy_any;

    tpu_controller #(.CFG_DEPTH(16)) uut (
        .clk(clk), .rst_n(rst_n),
        .instr_addr(instr_addr), .instr_data(instr_data),
        .sys_busy(sys_busy), .vpu_busy(vpu_busy), .dma_busy(dma_busy),
        .sys_cmd(sys_cmd), .ub_cmd(ub_cmd), .acc_cmd(acc_cmd),
        .vpu_cmd(vpu_cmd), .dma_cmd(dma_cmd),
        .ub_buf_sel(ub_buf_sel), .acc_buf_sel(acc_buf_sel),
        .halt_req(halt_req), .interrupt_en(interrupt_en),
        .pipeline_stall(pipeline_stall)
    );

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1);
    endtask

    function automatic int pick_busy_len();
        return 1 + int'({$random(seed)} % 32'd6);   // 1 to 6 cycles
    endfunction

    // ============================================================
    // Program building with expected commands
    // ============================================================

    task automatic put_word(input logic [5:0] op, input arg_t a1, a2, a3, input flags_t fl);
        prog[n_instr] = {op, a1, a2, a3, fl};
        n_instr++;
    endtask

    task automatic emit_dma(input logic wr, input arg_t a1, a2, a3, input flags_t fl);
        cmd_set_t c;
        c = '0;
        c.dma.start   = 1'b1;
        c.dma.dir     = wr;             // 1 towards host
        c.dma.ub_addr = a1;
        c.dma.length  = {a2, a3};
        c.dma.elem_sz = fl;
        put_word(wr ? WR_HOST_MEM : RD_HOST_MEM, a1, a2, a3, fl);
        exp_q.push_back(c);
        busy_budget += 6;
    endtask

    task automatic emit_matmul(input logic acc, input arg_t a1, a2, a3, input flags_t fl);
        cmd_set_t c;
        c = '0;
        c.sys.start     = 1'b1;
        c.sys.mode      = acc ? SYS_ACCUM : SYS_MATMUL;
        c.sys.rows      = a3;
        c.sys.is_signed = fl[1];
        c.sys.transpose = fl[0];
        c.sys.acc_addr  = a2;
        c.sys.acc_clear = !acc;
        c.ub.rd_en      = 1'b1;
        c.ub.rd_addr    = {bank_model, a1};     // Active bank
        c.ub.rd_count   = 9'd1;
        c.acc.wr_en     = 1'b1;
        c.acc.addr      = a2;
        put_word(acc ? MATMUL_ACC : MATMUL, a1, a2, a3, fl);
        exp_q.push_back(c);
        busy_budget += 6;
    endtask

    task automatic emit_relu(input logic six, input arg_t a1, a2, a3, input flags_t fl);
        cmd_set_t c;
        c = '0;
        c.vpu.start    = 1'b1;
        c.vpu.mode     = six ? VPU_RELU6 : VPU_RELU;
        c.vpu.in_addr  = a1;
        c.vpu.out_addr = a2;
        c.vpu.length   = a3;
        c.vpu.param    = fl[0] ? cfg_model[fl] : '0;
        c.acc.rd_en    = 1'b1;
        c.acc.addr     = a1;
        c.ub.wr_en     = 1'b1;
        c.ub.wr_addr   = {~bank_model, a2};     // Inactive bank
        c.ub.wr_count  = 9'd1;
        put_word(six ? RELU6 : RELU, a1, a2, a3, fl);
        exp_q.push_back(c);
        busy_budget += 6;
    endtask

    task automatic emit_cfg(input arg_t a1, a2, a3);
        put_word(CFG_REG, a1, a2, a3, 2'b00);
        cfg_model[a1[3:0]] = {a2, a3};
    endtask

    task automatic emit_sync(input unit_mask_t mask, input len_t tmo, input busy_win_t w);
        put_word(SYNC, {5'b0, mask}, tmo[15:8], tmo[7:0], 2'b00);
        bank_model = ~bank_model;               // Both banks swap
        win_q.push_back(w);
        busy_budget += int'(tmo) + int'(w.len) + 2;
    endtask

    task automatic build_program();
        logic [31:0] r;
        for (int i = 0; i < 256; i++) begin
            prog[i] = {NOP, 8'(i), 8'(~i), 8'(i ^ 'h5a), 2'(i)};
        end
        for (int i = 0; i < 16; i++) begin
            cfg_model[i] = '0;
        end
        emit_cfg(8'd1, 8'h01, 8'h23);
        emit_cfg(8'd3, 8'h0a, 8'hbc);
        emit_dma(1'b0, 8'h10, 8'h00, 8'h40, 2'b01);
        put_word(NOP, 8'hff, 8'hff, 8'hff, 2'b11);      // Args ignored
        emit_matmul(1'b0, 8'h10, 8'h05, 8'h08, 2'b10);
        emit_matmul(1'b1, 8'h11, 8'h05, 8'h08, 2'b01);
        put_word(6'h20, 8'h12, 8'h34, 8'h56, 2'b00);    // Retired opcode
        emit_relu(1'b0, 8'h05, 8'h20, 8'h10, 2'b01);    // Param from reg 1
        emit_sync(3'b001, 16'd4, {3'b001, 8'd2});       // Busy ends before timeout
        emit_matmul(1'b0, 8'h30, 8'h07, 8'h04, 2'b00);  // Bank 1 now
        emit_relu(1'b1, 8'h07, 8'h40, 8'h04, 2'b11);    // Param from reg 3
        emit_relu(1'b0, 8'h07, 8'h41, 8'h04, 2'b10);    // Param forced to 0
        emit_sync(3'b001, 16'd3, {3'b001, 8'd10});      // Busy outlives timeout
        emit_dma(1'b1, 8'h41, 8'h01, 8'h00, 2'b10);
        emit_sync(3'b001, 16'd8, {3'b010, 8'd5});       // Unmasked unit busy
        emit_sync(3'b111, 16'd6, {3'b000, 8'd0});
        emit_sync(3'b100, 16'd2, {3'b000, 8'd0});
        for (int i = 0; i < 6; i++) begin
            r = $random(seed);
            case (r[27:26])
                2'd0:    emit_dma(r[28], r[7:0], r[15:8], r[23:16], r[25:24]);
                2'd1:    emit_matmul(r[28], r[7:0], r[15:8], r[23:16], r[25:24]);
                default: emit_relu(r[28], r[7:0], r[15:8], r[23:16], r[25:24]);
            endcase
        end
        put_word(HALT, 8'h00, 8'h00, 8'h00, 2'b00);
        cycle_limit = 4 * n_instr + busy_budget + 40;   // Reset and halt tail
    endtask

    // ============================================================
    // Busy stimulus and scoreboard pop
    // ============================================================

    always @(negedge clk) begin
        if (rst_n) begin
            if (sys_left > 0) sys_left--;
            if (vpu_left > 0) vpu_left--;
            if (dma_left > 0) dma_left--;
            if (sys_cmd.start) sys_left = pick_busy_len();  // Unit works after start
            if (vpu_cmd.start) vpu_left = pick_busy_len();
            if (dma_cmd.start) dma_left = pick_busy_len();
            if (ub_buf_sel != bank_seen && win_q.size() > 0) begin
                bank_seen = ub_buf_sel;     // SYNC just issued
                win = win_q.pop_front();
                if (win.units[0]) sys_left = int'(win.len);
                if (win.units[1]) vpu_left = int'(win.len);
                if (win.units[2]) dma_left = int'(win.len);
            end
        end
        sys_busy <= (sys_left > 0);
        vpu_busy <= (vpu_left > 0);
        dma_busy <= (dma_left > 0);
    end

    always @(posedge clk) begin
        if (rst_n && any_pulse && exp_q.size() > 0) begin
            void'(exp_q.pop_front());
        end
        exp_avail <= (exp_q.size() > 0);
        exp_head  <= (exp_q.size() > 0) ? exp_q[0] : '0;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit)
            abort_run($sformatf("Run hung, HALT plus tail not done in %0d cycles", cycle_limit));
    end

    // ============================================================
    // Checks
    // ============================================================

    a_cmd_expected: assert property (@(posedge clk) disable iff (!rst_n)
        any_pulse |-> (exp_avail && seen == exp_head))
        else abort_run($sformatf("ERROR at %0t: command %h expected %h", $time, seen, exp_head));

    a_busy_freezes: assert property (@(posedge clk) disable iff (!rst_n)
        busy_any |=> (!any_pulse && $stable(instr_addr)))
        else abort_run($sformatf("ERROR at %0t: pulse or fetch under busy", $time));

    a_busy_stalls: assert property (@(posedge clk) disable iff (!rst_n)
        busy_any |-> pipeline_stall)
        else abort_run($sformatf("ERROR at %0t: busy without pipeline_stall", $time));

    // Sync wait outlasts busy by one cycle at most
    a_sync_release: assert property (@(posedge clk) disable iff (!rst_n)
        quiet_stall |=> !quiet_stall)
        else abort_run($sformatf("ERROR at %0t: sync wait held too long", $time));

    a_sync_stalls: assert property (@(posedge clk) disable iff (!rst_n)
        (ub_buf_sel != $past(ub_buf_sel)) |-> pipeline_stall)
        else abort_run($sformatf("ERROR at %0t: bank swap without sync wait", $time));

    a_banks_paired: assert property (@(posedge clk) disable iff (!rst_n)
        ub_buf_sel == acc_buf_sel)
        else abort_run($sformatf("ERROR at %0t: ub and acc banks differ", $time));

    a_halt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        halt_req |=> (halt_req && interrupt_en && $stable(instr_addr) && !any_pulse))
        else abort_run($sformatf("ERROR at %0t: activity after HALT", $time));

    a_irq_with_halt: assert property (@(posedge clk) disable iff (!rst_n)
        interrupt_en == halt_req)
        else abort_run($sformatf("ERROR at %0t: interrupt_en differs from halt_req", $time));

    // ============================================================
    // Main sequence
    // ============================================================

    initial begin
        build_program();
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        assert (seen == '0 && instr_addr == '0 && !pipeline_stall && !ub_buf_sel
                && !acc_buf_sel)
            else abort_run($sformatf("ERROR at %0t: outputs not idle after reset", $time));
        while (!halt_req) @(negedge clk);
        repeat (20) @(negedge clk);     // Quiet window after HALT
        if (exp_q.size() != 0 || ub_buf_sel != bank_model) begin
            abort_run($sformatf("ERROR at %0t: %0d commands missing, bank %0b expected %0b",
                                $time, exp_q.size(), ub_buf_sel, bank_model));
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: tpu_controller.f
hw/tpu_isa_pkg.sv
hw/tpu_ctrl_pkg.sv
hw/tpu_fetch.sv
hw/tpu_sync_unit.sv
hw/tpu_cfg_regs.sv
hw/tpu_exec_stage.sv
hw/tpu_controller.sv
tests/tb_tpu_controller.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_tpu_controller
FILELIST  := tpu_controller.f
BUILD_DIR := obj_dir
PASS_MSG  := all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	out=$$(./$(BUILD_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
